// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbPredecode
FILELIST = predecodeTop.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: design/boundaryScan.sv
// finds and counts the instruction starts of a fetch bundle for the slot packer
`timescale 1ns/100ps
`default_nettype none

`include "predecode_params.svh"

module boundaryScan (
  input  predecodePkg::bundleT    bundle,
  input  logic [`TAIL_W-1:0]      btail,
  input  predecodePkg::parcelIdxT startOff,
  output predecodePkg::scanT      scan
);

  import predecodePkg::*;

  logic [`PARCELS+2:0] ends;     // end markers padded with zeros past the tail
  logic [`PARCELS-1:0] prevEnd;  // end marker of the parcel before

  assign ends = {2'b00, btail[`TAIL_W-1], bundle[`BUNDLE_W-2:`END_LSB]};
  assign prevEnd = {ends[`PARCELS-2:0], 1'b1};  // parcel 0 always follows a boundary

  always_comb begin
    slotCountT cnt;

    cnt = '0;
    scan = '0;
    for (int k = 0; k < `PARCELS; k++) begin
      scan.starts[k] = (k >= startOff) && prevEnd[k];
      scan.lenCodes[k] = ~ends[k +: 4];
      if (scan.starts[k]) begin
        cnt = cnt + 5'd1;
      end
    end
    scan.count = cnt;
    // too many starts for the slots or nothing left to decode
    scan.overflow = (cnt > `SLOTS) || (startOff == `PARCELS);
  end

endmodule

`default_nettype wire

// File: design/instrClassify.sv
// decodes the class flags of one instruction from its first two parcels
`timescale 1ns/100ps
`default_nettype none

`include "predecode_params.svh"

module instrClassify (
  input  logic [31:0]              instr,
  input  logic                     isLong,
  output predecodePkg::instrClassT cls
);

  logic [7:0] opcMain;
  logic [5:0] opcSub;
  logic [2:0] indSel;

  assign opcMain = instr[7:0];
  assign opcSub = instr[5:0];
  assign indSel = instr[15:13];

  always_comb begin
    cls = '0;
    if (isLong) begin
      if (opcMain <= `OPC_BASIC_LAST) begin
        if (opcMain[2]) begin
          cls.mul = 1'b1;
        end else if (opcMain >= `OPC_XOR_FIRST) begin
          cls.shift = 1'b1;  // xor group
        end else begin
          cls.alu = 1'b1;
        end
      end else if (opcMain >= `OPC_SHIFT_FIRST && opcMain <= `OPC_SHIFT_LAST) begin
        cls.shift = 1'b1;
      end else if (opcMain >= `OPC_ALU_FIRST && opcMain <= `OPC_ALU_LAST) begin
        cls.alu = 1'b1;
      end else if (opcMain >= `OPC_LDST_FIRST && opcMain <= `OPC_LDST_LAST) begin
        cls.load = ~opcMain[0];
        cls.store = opcMain[0];
      end else if (opcMain >= `OPC_CJUMP_FIRST && opcMain <= `OPC_CJUMP_LAST) begin
        cls.jump = 1'b1;  // compare and branch
        cls.alu = 1'b1;
      end else if (opcMain == `OPC_JUMP_LONG || opcMain == `OPC_JUMP_UNCOND) begin
        cls.jump = 1'b1;
      end else if (opcMain == `OPC_CALL_IND) begin
        case (indSel)
          `IND_JUMP, `IND_RET: begin
            cls.jump = 1'b1;
            cls.indir = 1'b1;
          end
          `IND_CALL_A, `IND_CALL_B: begin
            cls.jump = 1'b1;
            cls.store = 1'b1;  // call pushes the return address
          end
          default: cls = '0;
        endcase
      end else if (opcMain >= `OPC_MOV_FIRST && opcMain <= `OPC_MOV_LAST) begin
        cls.alu = 1'b1;
      end else if (opcMain == `OPC_SHLADD_A || opcMain == `OPC_SHLADD_B) begin
        cls.alu = 1'b1;
      end else if (opcMain == `OPC_PTRSEC) begin
        cls.mul = 1'b1;
      end else if (opcMain == `OPC_FPU) begin
        cls.fpu = 1'b1;
      end else if (opcMain == `OPC_SYS) begin
        cls.sys = 1'b1;
      end
    end else begin
      // short forms
      if (opcSub <= `SUB_BASIC_LAST) begin
        cls.alu = ~opcSub[0];
        cls.shift = opcSub[0];
      end else if (opcSub <= `SUB_ALU_LAST) begin
        cls.alu = 1'b1;
      end else if (opcSub <= `SUB_CJ_LAST) begin
        cls.jump = 1'b1;
      end else begin
        cls.fpu = 1'b1;
        cls.alu = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/parcelClassify.sv
// classifies every parcel position as a possible instruction start for the slot packer
`timescale 1ns/100ps
`default_nettype none

`include "predecode_params.svh"

module parcelClassify (
  input  predecodePkg::bundleT                    bundle,
  input  logic [`TAIL_W-1:0]                      btail,
  output predecodePkg::instrClassT [`PARCELS-1:0] classes
);

  import predecodePkg::*;

  parcelT [`PARCELS:0] parcels;  // parcels 0..15 with the tail last
  logic   [`PARCELS-1:0] ends;

  assign parcels = {btail[`PARCEL_W-1:0], bundle[`END_LSB-1:0]};
  assign ends = bundle[`BUNDLE_W-2:`END_LSB];

  for (genvar k = 0; k < `PARCELS; k++) begin : genCls
    instrClassify uClassify (
      .instr  (parcels[k +: 2]),
      .isLong (~ends[k]),  // more parcels follow without an end marker
      .cls    (classes[k])
    );
  end

endmodule

`default_nettype wire

// File: design/predecodePkg.sv
// types shared by the predecoder blocks and the testbench, imported where needed
`default_nettype none

`include "predecode_params.svh"

package predecodePkg;

  typedef logic [`PARCEL_W-1:0]                   parcelT;
  typedef logic [`BUNDLE_W-1:0]                   bundleT;
  typedef logic [`WINDOW_PARCELS*`PARCEL_W-1:0]   windowT;
  typedef logic [3:0]                             lenCodeT;   // inverted end markers
  typedef logic [3:0]                             parcelIdxT;
  typedef logic [`PARCELS-1:0]                    startVecT;
  typedef logic [4:0]                             slotCountT;

  // execution unit hints for one instruction
  typedef struct packed {
    logic jump;
    logic indir;
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic fpu;
    logic sys;
  } instrClassT;

  typedef struct packed {
    instrClassT cls;
    lenCodeT    lenCode;
    windowT     window;
    parcelIdxT  off;
  } slotT;

  // boundary scan result, one entry per parcel position
  typedef struct packed {
    startVecT                    starts;
    slotCountT                   count;
    lenCodeT [`PARCELS-1:0]      lenCodes;
    logic                        overflow;
  } scanT;

endpackage

`default_nettype wire

// File: design/predecodeTop.sv
// predecoder top, takes one fetch bundle per cycle and gives its slots a cycle later
`timescale 1ns/100ps
`default_nettype none

`include "predecode_params.svh"

module predecodeTop (
  input  logic                                   clk,
  input  logic                                   reset,
  input  predecodePkg::bundleT                   bundle,
  input  logic [`TAIL_W-1:0]                     btail,
  input  predecodePkg::parcelIdxT                startOff,
  output predecodePkg::slotT [`SLOTS-1:0]        slots,
  output logic [`SLOTS-1:0]                      instrEn,
  output predecodePkg::slotT [`JUMP_SLOTS-1:0]   jumpSlots,
  output logic [`JUMP_SLOTS-1:0]                 jumpEn,
  output logic                                   hasJumps,
  output logic                                   error,
  output logic                                   jerror
);

  import predecodePkg::*;

  scanT                      scan;
  instrClassT [`PARCELS-1:0] classes;

  boundaryScan uScan (
    .bundle   (bundle),
    .btail    (btail),
    .startOff (startOff),
    .scan     (scan)
  );

  parcelClassify uClassify (
    .bundle  (bundle),
    .btail   (btail),
    .classes (classes)
  );

  slotPacker uPacker (
    .clk       (clk),
    .reset     (reset),
    .bundle    (bundle),
    .btail     (btail),
    .scan      (scan),
    .classes   (classes),
    .slots     (slots),
    .instrEn   (instrEn),
    .jumpSlots (jumpSlots),
    .jumpEn    (jumpEn),
    .hasJumps  (hasJumps),
    .error     (error),
    .jerror    (jerror)
  );

endmodule

`default_nettype wire

// File: design/predecode_params.svh
// counts, widths and opcode constants shared by the predecoder and its testbench
`ifndef PREDECODE_PARAMS_SVH
`define PREDECODE_PARAMS_SVH

`define PARCELS        15
`define SLOTS          12
`define JUMP_SLOTS     4
`define PARCEL_W       16
`define WINDOW_PARCELS 5
`define END_LSB        240
`define BUNDLE_W       256
`define TAIL_W         17

// long form main opcodes, instr[7:0]
`define OPC_XOR_FIRST    8'd32
`define OPC_BASIC_LAST   8'd39
`define OPC_SHIFT_FIRST  8'd40
`define OPC_SHIFT_LAST   8'd45
`define OPC_ALU_FIRST    8'd46
`define OPC_ALU_LAST     8'd53
`define OPC_LDST_FIRST   8'd64
`define OPC_LDST_LAST    8'd127
`define OPC_CJUMP_FIRST  8'd160
`define OPC_CJUMP_LAST   8'd175
`define OPC_JUMP_LONG    8'd180
`define OPC_JUMP_UNCOND  8'd181
`define OPC_CALL_IND     8'd182
`define OPC_MOV_FIRST    8'd183
`define OPC_MOV_LAST     8'd191
`define OPC_SHLADD_A     8'd210
`define OPC_SHLADD_B     8'd211
`define OPC_PTRSEC       8'd212
`define OPC_FPU          8'd240
`define OPC_SYS          8'd255

// opcode 182 selector, instr[15:13]
`define IND_JUMP 3'd0
`define IND_CALL_A 3'd1
`define IND_CALL_B 3'd2
`define IND_RET  3'd3

// short form sub-opcodes, instr[5:0]
`define SUB_BASIC_LAST 6'd31
`define SUB_ALU_LAST   6'd47
`define SUB_CJ_LAST    6'd51

`endif

// File: design/slotPacker.sv
// packs the instruction starts into registered instruction and jump slots
`timescale 1ns/100ps
`default_nettype none

`include "predecode_params.svh"

module slotPacker (
  input  logic                                       clk,
  input  logic                                       reset,
  input  predecodePkg::bundleT                       bundle,
  input  logic [`TAIL_W-1:0]                         btail,
  input  predecodePkg::scanT                         scan,
  input  predecodePkg::instrClassT [`PARCELS-1:0]    classes,
  output predecodePkg::slotT [`SLOTS-1:0]            slots,
  output logic [`SLOTS-1:0]                          instrEn,
  output predecodePkg::slotT [`JUMP_SLOTS-1:0]       jumpSlots,
  output logic [`JUMP_SLOTS-1:0]                     jumpEn,
  output logic                                       hasJumps,
  output logic                                       error,
  output logic                                       jerror
);

  import predecodePkg::*;

  // window source padded with zeros past the tail
  parcelT [`PARCELS+`WINDOW_PARCELS-2:0] parcels;

  slotT [`SLOTS-1:0]       nextSlots;
  logic [`SLOTS-1:0]       nextEn;
  slotT [`JUMP_SLOTS-1:0]  nextJumpSlots;
  logic [`JUMP_SLOTS-1:0]  nextJumpEn;
  logic                    nextHasJumps;
  logic                    nextJerror;

  assign parcels = {{(`WINDOW_PARCELS-2)*`PARCEL_W{1'b0}},
                    btail[`PARCEL_W-1:0], bundle[`END_LSB-1:0]};

  always_comb begin
    slotCountT n;
    slotCountT j;
    slotT      cur;

    n = '0;
    j = '0;
    nextSlots = '0;
    nextEn = '0;
    nextJumpSlots = '0;
    nextJumpEn = '0;
    for (int k = 0; k < `PARCELS; k++) begin
      cur.cls = classes[k];
      cur.lenCode = scan.lenCodes[k];
      cur.window = parcels[k +: `WINDOW_PARCELS];
      cur.off = parcelIdxT'(k);
      if (scan.starts[k]) begin
        if (n < `SLOTS) begin
          nextSlots[n[3:0]] = cur;
          nextEn[n[3:0]] = 1'b1;
        end
        n = n + 5'd1;  // starts past the last slot are dropped
        if (classes[k].jump) begin
          if (j < `JUMP_SLOTS) begin
            nextJumpSlots[j[1:0]] = cur;
            nextJumpEn[j[1:0]] = 1'b1;
          end
          j = j + 5'd1;
        end
      end
    end
    nextHasJumps = (j != '0);
    nextJerror = (j > `JUMP_SLOTS);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      slots <= '0;
      instrEn <= '0;
      jumpSlots <= '0;
      jumpEn <= '0;
      hasJumps <= 1'b0;
      error <= 1'b0;
      jerror <= 1'b0;
    end else begin
      slots <= nextSlots;
      instrEn <= nextEn;
      jumpSlots <= nextJumpSlots;
      jumpEn <= nextJumpEn;
      hasJumps <= nextHasJumps;
      error <= scan.overflow;
      jerror <= nextJerror;
    end
  end

endmodule

`default_nettype wire

// File: predecodeTop.f
+incdir+design
+incdir+sim
design/predecodePkg.sv
design/boundaryScan.sv
design/instrClassify.sv
design/parcelClassify.sv
design/slotPacker.sv
design/predecodeTop.sv
sim/tbPredecode.sv

// File: sim/tbPredecodeRef.svh
// reference model of the predecoder outputs that the testbench module includes
`ifndef TB_PREDECODE_REF_SVH
`define TB_PREDECODE_REF_SVH

// class flags straight from the opcode table
function automatic instrClassT classOf(input logic [31:0] instr, input logic isLong);
  instrClassT c;
  logic [7:0] op;
  logic [5:0] sub;
  logic [2:0] sel;

  c = '0;
  op = instr[7:0];
  sub = instr[5:0];
  sel = instr[15:13];
  if (isLong) begin
    case (op) inside
      [8'd0:8'd39]: begin
        if (op[2]) c.mul = 1'b1;
        else if (op >= 8'd32) c.shift = 1'b1;  // xor group
        else c.alu = 1'b1;
      end
      [8'd40:8'd45]: c.shift = 1'b1;
      [8'd46:8'd53], [8'd183:8'd191], 8'd210, 8'd211: c.alu = 1'b1;
      [8'd64:8'd127]: begin
        c.load = !op[0];
        c.store = op[0];
      end
      [8'd160:8'd175]: begin
        c.jump = 1'b1;
        c.alu = 1'b1;
      end
      8'd180, 8'd181: c.jump = 1'b1;
      8'd182: begin
        c.jump = (sel <= 3'd3);
        c.indir = (sel == 3'd0) || (sel == 3'd3);
        c.store = (sel == 3'd1) || (sel == 3'd2);  // calls
      end
      8'd212: c.mul = 1'b1;
      8'd240: c.fpu = 1'b1;
      8'd255: c.sys = 1'b1;
      default: c = '0;
    endcase
  end else begin
    case (sub) inside
      [6'd0:6'd31]: begin
        c.alu = !sub[0];
        c.shift = sub[0];
      end
      [6'd32:6'd47]: c.alu = 1'b1;
      [6'd48:6'd51]: c.jump = 1'b1;
      default: begin
        c.fpu = 1'b1;
        c.alu = 1'b1;
      end
    endcase
  end
  return c;
endfunction

// expected registered outputs for one set of inputs
function automatic expT refPredecode(input bundleT b, input logic [`TAIL_W-1:0] t,
                                     input parcelIdxT off);
  expT e;
  parcelT [18:0] p;       // zero past the tail
  logic [17:0] endMark;
  logic lastEnded;
  slotT s;
  int n;
  int j;

  e = '0;
  p = {48'd0, t[15:0], b[239:0]};
  endMark = {2'd0, t[16], b[254:240]};
  lastEnded = 1'b1;
  n = 0;
  j = 0;
  for (int k = 0; k < `PARCELS; k++) begin
    if (k >= off && lastEnded) begin
      s.cls = classOf({p[k+1], p[k]}, !endMark[k]);
      s.lenCode = ~endMark[k +: 4];
      s.window = p[k +: 5];
      s.off = parcelIdxT'(k);
      if (n < `SLOTS) begin
        e.slots[n] = s;
        e.instrEn[n] = 1'b1;
      end
      n++;
      if (s.cls.jump) begin
        if (j < `JUMP_SLOTS) begin
          e.jumpSlots[j] = s;
          e.jumpEn[j] = 1'b1;
        end
        j++;
      end
    end
    lastEnded = endMark[k];
  end
  e.error = (n > `SLOTS) || (off == 4'd15);
  e.hasJumps = (j > 0);
  e.jerror = (j > `JUMP_SLOTS);
  return e;
endfunction

`endif

// File: sim/tbPredecode.sv
// testbench for the predecoder that checks random and directed bundles against a reference model
`timescale 1ns/100ps
`default_nettype none

`include "predecode_params.svh"

module tbPredecode;

  import predecodePkg::*;

  localparam int numRand = 300;
  localparam int numLong = 4;    // seven long forms per bundle
  localparam int numShort = 6;   // twelve short forms per bundle
  localparam int numJump = 14;
  localparam int totalVecs = numRand + numLong + numShort + numJump;

  // one long form per opcode group and several 182 selectors
  localparam parcelT longOps [28] = '{
    16'h0000, 16'h0004, 16'h0021, 16'h0026, 16'h002a, 16'h0032, 16'h0040,
    16'h0041, 16'h007f, 16'h00a5, 16'h00b4, 16'h00b5, 16'h00b6, 16'h20b6,
    16'h40b6, 16'h60b6, 16'ha0b6, 16'h00b9, 16'h00d2, 16'h00d3, 16'h00d4,
    16'h00f0, 16'h00ff, 16'h0036, 16'h0082, 16'h00c8, 16'h0017, 16'h001c
  };

  typedef struct packed {
    slotT [`SLOTS-1:0]      slots;
    logic [`SLOTS-1:0]      instrEn;
    slotT [`JUMP_SLOTS-1:0] jumpSlots;
    logic [`JUMP_SLOTS-1:0] jumpEn;
    logic                   hasJumps;
    logic                   error;
    logic                   jerror;
  } expT;

  logic                   clk;
  logic                   reset;
  bundleT                 bundle;
  logic [`TAIL_W-1:0]     btail;
  parcelIdxT              startOff;
  slotT [`SLOTS-1:0]      slots;
  logic [`SLOTS-1:0]      instrEn;
  slotT [`JUMP_SLOTS-1:0] jumpSlots;
  logic [`JUMP_SLOTS-1:0] jumpEn;
  logic                   hasJumps;
  logic                   error;
  logic                   jerror;

  logic [31:0] lfsrState;
  int          checkCount = 0;
  int          errCount = 0;
  expT         expQ [$];   // one entry per rising edge

  `include "tbPredecodeRef.svh"

  predecodeTop dut0 (
    .clk       (clk),
    .reset     (reset),
    .bundle    (bundle),
    .btail     (btail),
    .startOff  (startOff),
    .slots     (slots),
    .instrEn   (instrEn),
    .jumpSlots (jumpSlots),
    .jumpEn    (jumpEn),
    .hasJumps  (hasJumps),
    .error     (error),
    .jerror    (jerror)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  task automatic takeBits(input int n, output logic [255:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[254:0], lfsrState[0]};
    end
  endtask

  function automatic parcelT jumpForm(input int sel);
    case (sel % 6)
      0: return 16'h00b6;  // indirect jump
      1: return 16'h20b6;  // call
      2: return 16'h40b6;
      3: return 16'h60b6;  // return
      4: return 16'h00b4;
      default: return 16'h00a5;
    endcase
  endfunction

  task automatic applyInputs(input bundleT b, input logic [`TAIL_W-1:0] t, input parcelIdxT off);
    @(negedge clk);
    bundle = b;
    btail = t;
    startOff = off;
  endtask

  // seven two-parcel instructions and a short form in parcel 14
  task automatic driveLongs(input parcelT [6:0] firsts, input logic [5:0] shortSub);
    bundleT b;
    logic [255:0] r;

    takeBits(256, r);
    b = r;
    for (int i = 0; i < 7; i++) begin
      b[2*i*`PARCEL_W +: `PARCEL_W] = firsts[i];
      b[`END_LSB + 2*i] = 1'b0;
      b[`END_LSB + 2*i + 1] = 1'b1;
    end
    b[14*`PARCEL_W +: 6] = shortSub;
    b[`END_LSB + 14] = 1'b1;
    takeBits(17, r);
    applyInputs(b, r[16:0], 4'd0);
  endtask

  task automatic compareOutputs(input expT e);
    checkCount++;
    for (int n = 0; n < `SLOTS; n++) begin
      assert (slots[n] === e.slots[n]) else begin
        $display("ERR slots[%0d] expected %h got %h", n, e.slots[n], slots[n]);
        errCount++;
      end
    end
    for (int j = 0; j < `JUMP_SLOTS; j++) begin
      assert (jumpSlots[j] === e.jumpSlots[j]) else begin
        $display("ERR jumpSlots[%0d] expected %h got %h", j, e.jumpSlots[j], jumpSlots[j]);
        errCount++;
      end
    end
    assert (instrEn === e.instrEn) else begin
      $display("ERR instrEn expected %h got %h", e.instrEn, instrEn);
      errCount++;
    end
    assert (jumpEn === e.jumpEn) else begin
      $display("ERR jumpEn expected %h got %h", e.jumpEn, jumpEn);
      errCount++;
    end
    assert ({hasJumps, error, jerror} === {e.hasJumps, e.error, e.jerror}) else begin
      $display("ERR hasJumps/error/jerror expected %h got %h",
               {e.hasJumps, e.error, e.jerror}, {hasJumps, error, jerror});
      errCount++;
    end
  endtask

  // outputs seen at an edge belong to the inputs sampled one edge earlier
  always @(posedge clk) begin
    if (expQ.size() > 0) begin
      compareOutputs(expQ.pop_front());
    end
    if (reset) begin
      expQ.push_back(expT'(0));
    end else begin
      expQ.push_back(refPredecode(bundle, btail, startOff));
    end
  end

  initial begin
    bundleT             b;
    logic [255:0]       r;
    logic [`TAIL_W-1:0] t;
    parcelT [6:0]       firsts;
    int                 nj;

    lfsrState = 32'hc36b;
    reset = 1'b1;
    bundle = '0;
    btail = '0;
    startOff = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    assert (instrEn == '0 && jumpEn == '0 && !hasJumps && !error && !jerror) else begin
      $display("enables or flags were not cleared by reset");
      errCount++;
    end

    for (int i = 0; i < numRand; i++) begin
      takeBits(256, r);
      b = r;
      takeBits(15, r);
      case (i % 4)
        1: b[`END_LSB +: `PARCELS] = b[`END_LSB +: `PARCELS] | r[14:0];  // denser end markers
        2: b[`END_LSB +: `PARCELS] = '1;
        3: b[`END_LSB +: `PARCELS] = b[`END_LSB +: `PARCELS] & r[14:0];
        default: ;
      endcase
      takeBits(17, r);
      t = r[16:0];
      takeBits(4, r);
      applyInputs(b, t, (i % 32 == 5) ? 4'd15 : r[3:0]);
    end

    for (int g = 0; g < numLong; g++) begin
      for (int i = 0; i < 7; i++) begin
        firsts[i] = longOps[g*7 + i];
      end
      driveLongs(firsts, 6'(48 + g * 4));
    end

    // starts at parcels 3..14 fill all twelve slots
    for (int g = 0; g < numShort; g++) begin
      takeBits(256, r);
      b = r;
      b[`END_LSB +: `PARCELS] = '1;
      for (int k = 3; k < `PARCELS; k++) begin
        b[k*`PARCEL_W +: 6] = 6'(g * 12 + k - 3);
      end
      takeBits(17, r);
      applyInputs(b, r[16:0], 4'd3);
    end

    for (int i = 0; i < numJump; i++) begin
      nj = i % 7;
      for (int k = 0; k < 7; k++) begin
        // second pass puts the jumps last and a short jump behind them
        if ((i < 7) ? (k < nj) : (k >= 7 - nj)) firsts[k] = jumpForm(k + i);
        else firsts[k] = 16'h0002;
      end
      driveLongs(firsts, (i < 7) ? 6'd40 : 6'd49);
    end

    repeat (2) @(negedge clk);
    $display("checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #((totalVecs + 20) * 10);
    $display("watchdog expired before the stimulus finished");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
